//--- common/sentinel_pkg.sv
/* Shared types, the unlock key and the display codes of the access gate.
   All blocks refer to these by scoped name. */

package sentinel_pkg;

    // Authorization key as presented on the key pins
    typedef logic [7:0] key_t;

    // Seven-segment code, bit order dp g f e d c b a
    // Active low: a zero lights the segment
    typedef logic [7:0] seg_t;

    // Status nibble, driven out and read back on the loopback pins
    typedef logic [3:0] status_t;

    // Probe-watch pins, any toggle here means someone is poking the chip
    typedef logic [3:0] probe_t;

    // Cycles since the session enable rose, saturates at all ones
    typedef logic [5:0] cycle_count_t;

    // Remaining cycles of a replay lockout
    typedef logic [15:0] lockout_count_t;

    // Gate FSM states
    typedef enum logic [1:0] {
        ST_IDLE,        // Waiting for a rise of ena
        ST_WAITING,     // Window counter running, no key seen yet
        ST_AUTHORIZED,  // Valid key inside the window, held
        ST_LOCKOUT      // Replay detected, keys refused
    } gate_state_e;

    // The one key that opens the gate
    localparam key_t KEY_VALUE = 8'hB6;

    // Letter L, segments f e d lit
    localparam seg_t SEG_LOCKED = 8'hC7;

    // Letter U, segments f e d c b lit
    localparam seg_t SEG_VERIFIED = 8'hC1;

    // Display dark while the session is off
    localparam seg_t SEG_OFF = 8'hFF;

    // Every segment driven, the brick pattern
    localparam seg_t SEG_BRICK = 8'h00;

    // Status nibble patterns
    localparam status_t STATUS_ON  = 4'hF;
    localparam status_t STATUS_OFF = 4'h0;

endpackage

//--- gate/window_gate.sv
/* Key-window FSM of the access gate. A rise of ena starts a cycle counter;
   a key seen inside the window authorizes, a key seen too early or too late
   starts a replay lockout of fixed length. */

module window_gate #(
    parameter int unsigned WINDOW_OPEN    = 3,
    parameter int unsigned WINDOW_CLOSE   = 5,
    parameter int unsigned LATE_LIMIT     = 10,
    parameter int unsigned LOCKOUT_CYCLES = 20
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               ena,
    input  sentinel_pkg::key_t key_in,
    input  logic               fuse_ok,
    output logic               authorized
);

    // Limits in counter width
    localparam sentinel_pkg::cycle_count_t OPEN_AT =
        sentinel_pkg::cycle_count_t'(WINDOW_OPEN);
    localparam sentinel_pkg::cycle_count_t CLOSE_AT =
        sentinel_pkg::cycle_count_t'(WINDOW_CLOSE);
    localparam sentinel_pkg::cycle_count_t LATE_AT =
        sentinel_pkg::cycle_count_t'(LATE_LIMIT);
    localparam sentinel_pkg::cycle_count_t COUNT_MAX = '1;

    // Timer load value, one decrement per edge spent in lockout
    localparam sentinel_pkg::lockout_count_t LOCK_LOAD =
        sentinel_pkg::lockout_count_t'(LOCKOUT_CYCLES);

    sentinel_pkg::gate_state_e    state;
    sentinel_pkg::gate_state_e    state_next;
    sentinel_pkg::cycle_count_t   count;
    sentinel_pkg::cycle_count_t   count_next;
    sentinel_pkg::lockout_count_t timer;
    sentinel_pkg::lockout_count_t timer_next;

    logic ena_q;
    logic ena_rise;
    logic key_present;
    logic key_replay;
    logic key_in_window;

    // Rise seen against last cycle's copy of ena
    assign ena_rise = ena && !ena_q;

    // A blown fuse makes the right key look absent
    assign key_present = (key_in == sentinel_pkg::KEY_VALUE) && fuse_ok;

    // Counter 0 means the key was already there at the rise
    assign key_replay = (count == '0) || (count >= LATE_AT);

    assign key_in_window = (count >= OPEN_AT) && (count <= CLOSE_AT);

    always_comb begin
        state_next = state;
        count_next = count;
        timer_next = timer;

        case (state)
            sentinel_pkg::ST_IDLE: begin
                count_next = '0;
                if (ena_rise) begin
                    state_next = sentinel_pkg::ST_WAITING;
                end
            end

            sentinel_pkg::ST_WAITING: begin
                // Counter keeps running until it saturates
                if (count != COUNT_MAX) begin
                    count_next = count + 1'b1;
                end
                if (!ena) begin
                    state_next = sentinel_pkg::ST_IDLE;
                end else if (key_present && key_replay) begin
                    state_next = sentinel_pkg::ST_LOCKOUT;
                    timer_next = LOCK_LOAD;
                end else if (key_present && key_in_window) begin
                    state_next = sentinel_pkg::ST_AUTHORIZED;
                end
                // Key between 1 and the window open just keeps waiting
            end

            sentinel_pkg::ST_AUTHORIZED: begin
                // Holding the key keeps the gate open
                if (!ena || !key_present) begin
                    state_next = sentinel_pkg::ST_IDLE;
                end
            end

            sentinel_pkg::ST_LOCKOUT: begin
                if (!ena) begin
                    state_next = sentinel_pkg::ST_IDLE;
                    timer_next = '0;
                end else if (timer > 16'd1) begin
                    timer_next = timer - 1'b1;
                end else begin
                    // Last lockout edge
                    state_next = sentinel_pkg::ST_IDLE;
                    timer_next = '0;
                end
            end

            default: begin
                state_next = sentinel_pkg::ST_IDLE;
                count_next = '0;
                timer_next = '0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= sentinel_pkg::ST_IDLE;
            count <= '0;
            timer <= '0;
            ena_q <= 1'b0;
        end else begin
            state <= state_next;
            count <= count_next;
            timer <= timer_next;
            ena_q <= ena;
        end
    end

    // Straight from the state register
    assign authorized = (state == sentinel_pkg::ST_AUTHORIZED);

endmodule

//--- tamper/tamper_monitor.sv
/* Tamper checks of the access gate. Bricks the gate on any probe toggle
   during a session and blows the key fuse when the driven status keeps
   disagreeing with its read-back copy. */

module tamper_monitor #(
    parameter int unsigned FIGHT_LIMIT = 2
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  ena,
    input  sentinel_pkg::probe_t  probe_in,
    input  sentinel_pkg::status_t status_in,
    input  sentinel_pkg::status_t status_out,
    output logic                  bricked,
    output logic                  fuse_ok
);

    // Counter wide enough to hold FIGHT_LIMIT itself
    localparam int unsigned FIGHT_W = (FIGHT_LIMIT < 2) ? 1 : $clog2(FIGHT_LIMIT + 1);
    localparam logic [FIGHT_W-1:0] FIGHT_MAX = FIGHT_W'(FIGHT_LIMIT);

    sentinel_pkg::probe_t probe_q;

    logic               probe_toggle;
    logic               mismatch;
    logic [FIGHT_W-1:0] fight_count;
    logic [FIGHT_W-1:0] fight_next;
    logic               fight_reached;

    // Probe pins against their value at the previous edge
    assign probe_toggle = ena && (probe_in != probe_q);

    // Probe history follows the pins all the time
    // so a session start never looks like a toggle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            probe_q <= '0;
        end else begin
            probe_q <= probe_in;
        end
    end

    // Brick latch, only a session end or reset releases it
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bricked <= 1'b0;
        end else if (!ena) begin
            bricked <= 1'b0;
        end else if (probe_toggle) begin
            bricked <= 1'b1;
        end
    end

    // Something outside is fighting our status drivers
    assign mismatch = (status_out != status_in);

    // Run length of the mismatch, held at the limit
    assign fight_next = (fight_count == FIGHT_MAX) ? FIGHT_MAX : fight_count + 1'b1;

    assign fight_reached = mismatch && (fight_next == FIGHT_MAX);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fight_count <= '0;
        end else if (mismatch) begin
            fight_count <= fight_next;
        end else begin
            // Any matching cycle restarts the run
            fight_count <= '0;
        end
    end

    // Key fuse, once blown stays blown until reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fuse_ok <= 1'b1;
        end else if (fight_reached) begin
            fuse_ok <= 1'b0;
        end
    end

endmodule

//--- design/display_driver.sv
/* Registered display outputs of the access gate. Turns the gate and tamper
   flags into the 7-segment code and the status nibble. */

module display_driver (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  ena,
    input  logic                  authorized,
    input  logic                  bricked,
    output sentinel_pkg::seg_t    seg_out,
    output sentinel_pkg::status_t status_out
);

    sentinel_pkg::seg_t    seg_next;
    sentinel_pkg::status_t status_next;

    // Brick wins over everything, then session off, then the gate result
    always_comb begin
        if (bricked) begin
            seg_next = sentinel_pkg::SEG_BRICK;
        end else if (!ena) begin
            seg_next = sentinel_pkg::SEG_OFF;
        end else if (authorized) begin
            seg_next = sentinel_pkg::SEG_VERIFIED;
        end else begin
            seg_next = sentinel_pkg::SEG_LOCKED;
        end
    end

    // Status lights only for a clean, live, authorized session
    assign status_next = (!bricked && ena && authorized) ?
        sentinel_pkg::STATUS_ON : sentinel_pkg::STATUS_OFF;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            seg_out    <= sentinel_pkg::SEG_OFF;
            status_out <= sentinel_pkg::STATUS_OFF;
        end else begin
            seg_out    <= seg_next;
            status_out <= status_next;
        end
    end

endmodule

//--- design/sentinel_top.sv
/* Top level of the access gate. Sets the timing and fuse parameters and
   ties the window FSM, the tamper monitor and the display together. */

module sentinel_top #(
    parameter int unsigned WINDOW_OPEN    = 3,
    parameter int unsigned WINDOW_CLOSE   = 5,
    parameter int unsigned LATE_LIMIT     = 10,
    parameter int unsigned LOCKOUT_CYCLES = 20,
    parameter int unsigned FIGHT_LIMIT    = 2
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  ena,
    input  sentinel_pkg::key_t    key_in,
    input  sentinel_pkg::probe_t  probe_in,
    input  sentinel_pkg::status_t status_in,
    output sentinel_pkg::seg_t    seg_out,
    output sentinel_pkg::status_t status_out
);

    logic authorized;
    logic bricked;
    logic fuse_ok;

    // Key window and replay lockout
    window_gate #(
        .WINDOW_OPEN    (WINDOW_OPEN),
        .WINDOW_CLOSE   (WINDOW_CLOSE),
        .LATE_LIMIT     (LATE_LIMIT),
        .LOCKOUT_CYCLES (LOCKOUT_CYCLES)
    ) window_gate_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .ena        (ena),
        .key_in     (key_in),
        .fuse_ok    (fuse_ok),
        .authorized (authorized)
    );

    // Status readback loop closes here: our own output against the pins
    tamper_monitor #(
        .FIGHT_LIMIT (FIGHT_LIMIT)
    ) tamper_monitor_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .ena        (ena),
        .probe_in   (probe_in),
        .status_in  (status_in),
        .status_out (status_out),
        .bricked    (bricked),
        .fuse_ok    (fuse_ok)
    );

    display_driver display_driver_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .ena        (ena),
        .authorized (authorized),
        .bricked    (bricked),
        .seg_out    (seg_out),
        .status_out (status_out)
    );

endmodule

//--- bench/sentinel_properties.sv
/* Concurrent checks on the access gate top level, attached with bind.
   Ties the status nibble to the verified code and the display to a real key. */

module sentinel_properties (
    input logic                  clk,
    input logic                  rst_n,
    input sentinel_pkg::key_t    key_in,
    input sentinel_pkg::seg_t    seg_out,
    input sentinel_pkg::status_t status_out
);

    // Set once the unlock key was on the pins at some edge since reset
    logic key_seen;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            key_seen <= 1'b0;
        end else if (key_in == sentinel_pkg::KEY_VALUE) begin
            key_seen <= 1'b1;
        end
    end

    // Status lights only together with the verified code
    status_on_only_verified: assert property (
        @(posedge clk) disable iff (!rst_n)
        (status_out == sentinel_pkg::STATUS_ON) |-> (seg_out == sentinel_pkg::SEG_VERIFIED)
    ) else $error("status_out on while seg_out shows %h", seg_out);

    brick_never_with_status: assert property (
        @(posedge clk) disable iff (!rst_n)
        !((seg_out == sentinel_pkg::SEG_BRICK) && (status_out == sentinel_pkg::STATUS_ON))
    ) else $error("Brick code shown with status on");

    // No verified display out of thin air
    verified_needs_key: assert property (
        @(posedge clk) disable iff (!rst_n)
        (seg_out == sentinel_pkg::SEG_VERIFIED) |-> key_seen
    ) else $error("Verified display without the unlock key seen since reset");

endmodule

bind sentinel_top sentinel_properties sentinel_properties_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .key_in     (key_in),
    .seg_out    (seg_out),
    .status_out (status_out)
);

//--- bench/sentinel_tb.sv
/* Data-driven testbench of the access gate. Reads one test per line from the
   tests file, drives the pins on the falling clock edge and checks the display. */

module sentinel_tb;

    localparam int WINDOW_OPEN    = 3;
    localparam int WINDOW_CLOSE   = 5;
    localparam int LATE_LIMIT     = 10;
    localparam int LOCKOUT_CYCLES = 20;
    localparam int FIGHT_LIMIT    = 2;

    // Longest wait for a display change
    localparam int WAIT_LIMIT = 50;

    logic                  clk;
    logic                  rst_n;
    logic                  ena;
    sentinel_pkg::key_t    key_in;
    sentinel_pkg::probe_t  probe_in;
    sentinel_pkg::status_t status_in;
    sentinel_pkg::seg_t    seg_out;
    sentinel_pkg::status_t status_out;

    // Falling edges left with a corrupted status echo
    int fault_left;

    sentinel_top #(
        .WINDOW_OPEN    (WINDOW_OPEN),
        .WINDOW_CLOSE   (WINDOW_CLOSE),
        .LATE_LIMIT     (LATE_LIMIT),
        .LOCKOUT_CYCLES (LOCKOUT_CYCLES),
        .FIGHT_LIMIT    (FIGHT_LIMIT)
    ) sentinel_top_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .ena        (ena),
        .key_in     (key_in),
        .probe_in   (probe_in),
        .status_in  (status_in),
        .seg_out    (seg_out),
        .status_out (status_out)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    task automatic stop_with_failure();
        $display("Errors found");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic compare_seg(input string name, input sentinel_pkg::seg_t expected,
                               input sentinel_pkg::seg_t actual);
        if (actual !== expected) begin
            $display("Fail %s: seg_out expected %h, actual %h", name, expected, actual);
            stop_with_failure();
        end
    endtask

    task automatic compare_status(input string name, input sentinel_pkg::status_t expected,
                                  input sentinel_pkg::status_t actual);
        if (actual !== expected) begin
            $display("Fail %s: status_out expected %h, actual %h", name, expected, actual);
            stop_with_failure();
        end
    endtask

    task automatic check_display(input string name, input sentinel_pkg::seg_t exp_seg,
                                 input sentinel_pkg::status_t exp_status);
        compare_seg(name, exp_seg, seg_out);
        compare_status(name, exp_status, status_out);
    endtask

    // Any key except the unlock key
    function automatic sentinel_pkg::key_t wrong_key();
        sentinel_pkg::key_t k;
        k = sentinel_pkg::key_t'($urandom);
        if (k == sentinel_pkg::KEY_VALUE) begin
            k = ~k;
        end
        return k;
    endfunction

    // Counter value at which the gate decides, key held from counter n on
    function automatic int deciding_count(input int n);
        if (n == 0 || n >= LATE_LIMIT) begin
            return n;
        end
        if (n < WINDOW_OPEN) begin
            return WINDOW_OPEN;
        end
        if (n <= WINDOW_CLOSE) begin
            return n;
        end
        return LATE_LIMIT;
    endfunction

    // Next falling edges, status pins echo status_out unless a fault is running
    task automatic step(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            if (fault_left > 0) begin
                status_in = ~status_out;
                fault_left--;
            end else begin
                status_in = status_out;
            end
        end
    endtask

    task automatic wait_seg(input sentinel_pkg::seg_t expected, input string what);
        int cycles;
        cycles = 0;
        while (seg_out !== expected && cycles < WAIT_LIMIT) begin
            step(1);
            cycles++;
        end
        if (seg_out !== expected) begin
            $display("Timeout after %0d cycles waiting for %s", WAIT_LIMIT, what);
            stop_with_failure();
        end
    endtask

    // Probe pins back to zero too, the probe history restarts at zero
    task automatic apply_reset();
        rst_n = 1'b0;
        ena = 1'b0;
        key_in = wrong_key();
        probe_in = '0;
        fault_left = 0;
        step(2);
        rst_n = 1'b1;
    endtask

    // Ends on the falling edge before the edge that sees counter 0
    task automatic start_session();
        ena = 1'b1;
        key_in = wrong_key();
        wait_seg(sentinel_pkg::SEG_LOCKED, "the locked display after ena rose");
    endtask

    task automatic end_session();
        ena = 1'b0;
        key_in = wrong_key();
        wait_seg(sentinel_pkg::SEG_OFF, "the display to go dark after ena fell");
    endtask

    // Key first seen at counter n, checked 2 cycles after the deciding edge
    task automatic run_window(input string name, input int n, input sentinel_pkg::seg_t exp_seg,
                              input sentinel_pkg::status_t exp_status);
        start_session();
        step(n);
        key_in = sentinel_pkg::KEY_VALUE;
        step(deciding_count(n) - n + 2);
        check_display(name, exp_seg, exp_status);
    endtask

    task automatic lockout_test(input string name, input int n, input sentinel_pkg::seg_t exp_seg,
                                input sentinel_pkg::status_t exp_status);
        run_window(name, n, exp_seg, exp_status);
        // Valid key stays on the pins through the whole lockout
        for (int i = 0; i < LOCKOUT_CYCLES; i++) begin
            step(1);
            check_display({name, "/held"}, sentinel_pkg::SEG_LOCKED, sentinel_pkg::STATUS_OFF);
        end
        end_session();
        run_window({name, "/new_session"}, WINDOW_OPEN, sentinel_pkg::SEG_VERIFIED,
                   sentinel_pkg::STATUS_ON);
    endtask

    task automatic brick_test(input string name, input int mask, input sentinel_pkg::seg_t exp_seg,
                              input sentinel_pkg::status_t exp_status);
        run_window({name, "/setup"}, WINDOW_OPEN, sentinel_pkg::SEG_VERIFIED,
                   sentinel_pkg::STATUS_ON);
        probe_in = probe_in ^ sentinel_pkg::probe_t'(mask);
        step(2);
        check_display(name, exp_seg, exp_status);
        step(3);
        check_display({name, "/held"}, exp_seg, exp_status);
        // Session end releases the brick
        end_session();
        run_window({name, "/cleared"}, WINDOW_OPEN, sentinel_pkg::SEG_VERIFIED,
                   sentinel_pkg::STATUS_ON);
    endtask

    task automatic fight_test(input string name, input int length, input sentinel_pkg::seg_t exp_seg,
                              input sentinel_pkg::status_t exp_status);
        run_window({name, "/setup"}, WINDOW_OPEN, sentinel_pkg::SEG_VERIFIED,
                   sentinel_pkg::STATUS_ON);
        fault_left = length;
        step(length + 4);
        check_display(name, exp_seg, exp_status);
        if (length >= FIGHT_LIMIT) begin
            // Blown fuse refuses a timely key until reset
            end_session();
            run_window({name, "/later_key"}, WINDOW_OPEN, sentinel_pkg::SEG_LOCKED,
                       sentinel_pkg::STATUS_OFF);
            end_session();
            apply_reset();
            run_window({name, "/after_reset"}, WINDOW_OPEN, sentinel_pkg::SEG_VERIFIED,
                       sentinel_pkg::STATUS_ON);
        end
    endtask

    task automatic run_test(input string name, input string kind, input int param,
                            input sentinel_pkg::seg_t exp_seg,
                            input sentinel_pkg::status_t exp_status);
        $display("Running %s", name);
        apply_reset();
        case (kind)
            "idle": begin
                step(param);
                check_display(name, exp_seg, exp_status);
            end
            "enable": begin
                ena = 1'b1;
                key_in = wrong_key();
                step(param + 2);
                check_display(name, exp_seg, exp_status);
            end
            "window": begin
                run_window(name, param, exp_seg, exp_status);
                key_in = wrong_key();
                step(2);
                check_display({name, "/key_removed"}, sentinel_pkg::SEG_LOCKED,
                              sentinel_pkg::STATUS_OFF);
            end
            "lockout": lockout_test(name, param, exp_seg, exp_status);
            "brick": brick_test(name, param, exp_seg, exp_status);
            "fight": fight_test(name, param, exp_seg, exp_status);
            default: begin
                $display("Unknown test kind %s in test %s", kind, name);
                stop_with_failure();
            end
        endcase
        end_session();
    endtask

    initial begin
        int fd;
        int fields;
        int tests_run;
        int param;
        int seg_raw;
        int status_raw;
        string line;
        string name;
        string kind;

        void'($urandom(32'h9860_092f));
        rst_n = 1'b0;
        ena = 1'b0;
        key_in = wrong_key();
        probe_in = '0;
        status_in = '0;
        fault_left = 0;
        tests_run = 0;

        fd = $fopen("bench/sentinel_tests.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the test list bench/sentinel_tests.txt");
            stop_with_failure();
        end else begin
            while ($fgets(line, fd) != 0) begin
                // Blank and comment lines carry no test
                if (line.len() < 2 || line.substr(0, 0) == "#") begin
                    continue;
                end
                fields = $sscanf(line, "%s %s %d %h %h", name, kind, param, seg_raw, status_raw);
                if (fields != 5) begin
                    $display("Malformed line in the test list: %s", line);
                    stop_with_failure();
                end else begin
                    run_test(name, kind, param, sentinel_pkg::seg_t'(seg_raw),
                             sentinel_pkg::status_t'(status_raw));
                    tests_run++;
                end
            end
            $fclose(fd);
            if (tests_run == 0) begin
                $display("The test list holds no tests");
                stop_with_failure();
            end else begin
                $display("No errors");
                $finish;
            end
        end
    end

endmodule

//--- bench/sentinel_tests.txt
# Columns: name kind param expected_seg(hex) expected_status(hex)
# param: wait cycles (idle, enable), key start counter (window, lockout),
# probe toggle mask (brick), corrupted echo cycles (fight)
idle_after_reset     idle     3  ff 0
enable_wrong_key     enable   0  c7 0
enable_wrong_key_2   enable   4  c7 0
window_n0            window   0  c7 0
window_n1            window   1  c1 f
window_n2            window   2  c1 f
window_n3            window   3  c1 f
window_n4            window   4  c1 f
window_n5            window   5  c1 f
window_n6            window   6  c7 0
window_n7            window   7  c7 0
window_n8            window   8  c7 0
window_n9            window   9  c7 0
window_n10           window   10 c7 0
window_n11           window   11 c7 0
window_n20           window   20 c7 0
lockout_early        lockout  0  c7 0
lockout_late         lockout  10 c7 0
lockout_very_late    lockout  15 c7 0
brick_bit0           brick    1  00 0
brick_bit3           brick    8  00 0
brick_all_bits       brick    15 00 0
fight_one_cycle      fight    1  c1 f
fight_two_cycles     fight    2  c7 0
fight_three_cycles   fight    3  c7 0
fight_six_cycles     fight    6  c7 0

//--- sentinel_top.f
common/sentinel_pkg.sv
gate/window_gate.sv
tamper/tamper_monitor.sv
design/display_driver.sv
design/sentinel_top.sv
bench/sentinel_properties.sv
bench/sentinel_tb.sv

//--- Makefile
# Verilator build and run of the access gate testbench

VERILATOR ?= verilator
TOP       ?= sentinel_tb
FILELIST  ?= sentinel_top.f
OBJ_DIR   ?= ./obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))
TESTS   := bench/sentinel_tests.txt

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only when the log holds the pass line
run: $(SIM_BIN) $(TESTS)
	-$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "No errors" $(LOG) && echo "PASS" || (echo "FAIL, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
